/* include/lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// data and address width
`define LSU_DATA_W 32

// cache index bits, two lines
`define LSU_L1D_IDX_W 1

// cacheable windows, base inclusive and end exclusive
// sram
`define LSU_CACHE_BASE0 32'h3000_0000
`define LSU_CACHE_END0  32'h4000_0000
// main memory
`define LSU_CACHE_BASE1 32'h8000_0000
`define LSU_CACHE_END1  32'h8040_0000
// psram
`define LSU_CACHE_BASE2 32'hA000_0000
`define LSU_CACHE_END2  32'hC000_0000

`endif

/* source/lsu_pkg.sv */
package lsu_pkg;

  // memory opcode from the execute stage
  typedef enum logic [3:0] {
    MEM_NONE = 4'd0,
    MEM_LB   = 4'd1,
    MEM_LBU  = 4'd2,
    MEM_LH   = 4'd3,
    MEM_LHU  = 4'd4,
    MEM_LW   = 4'd5,
    MEM_SB   = 4'd6,
    MEM_SH   = 4'd7,
    MEM_SW   = 4'd8
  } mem_op_e;

  // request generator state
  typedef enum logic [1:0] {
    REQ_IDLE  = 2'd0,
    REQ_READ  = 2'd1,
    REQ_WRITE = 2'd2,
    REQ_DONE  = 2'd3
  } req_state_e;

  // any of the five loads
  function automatic logic is_load_op(input mem_op_e op);
    return (op == MEM_LB) || (op == MEM_LBU) || (op == MEM_LH) ||
           (op == MEM_LHU) || (op == MEM_LW);
  endfunction

  // any of the three stores
  function automatic logic is_store_op(input mem_op_e op);
    return (op == MEM_SB) || (op == MEM_SH) || (op == MEM_SW);
  endfunction

endpackage

/* source/lsu_req_gen.sv */
`include "lsu_config.svh"

module lsu_req_gen import lsu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`LSU_DATA_W-1:0] addr_i,
  input  mem_op_e                mem_op_i,
  input  logic                   avalid_i,
  input  logic [`LSU_DATA_W-1:0] wdata_i,
  input  logic                   hit_i,
  input  logic                   bus_rvalid_i,
  input  logic                   bus_wready_i,
  output logic [`LSU_DATA_W-1:0] araddr_o,
  output logic                   arvalid_o,
  output logic [7:0]             rstrb_o,
  output logic [`LSU_DATA_W-1:0] awaddr_o,
  output logic                   awvalid_o,
  output logic [`LSU_DATA_W-1:0] wdata_o,
  output logic [7:0]             wstrb_o,
  output logic                   wvalid_o
);

  req_state_e             state_q;
  req_state_e             state_cur;
  req_state_e             state_d;
  logic [`LSU_DATA_W-1:0] addr_q;
  mem_op_e                op_q;
  logic                   req_changed;
  logic                   req_start;

  // byte lanes from the access size
  always_comb begin
    rstrb_o = 8'h00;
    wstrb_o = 8'h00;
    case (mem_op_i)
      MEM_LB, MEM_LBU: rstrb_o = 8'h01;
      MEM_LH, MEM_LHU: rstrb_o = 8'h03;
      MEM_LW:          rstrb_o = 8'h0f;
      MEM_SB:          wstrb_o = 8'h01;
      MEM_SH:          wstrb_o = 8'h03;
      MEM_SW:          wstrb_o = 8'h0f;
      default:         ;
    endcase
  end

  // a new request starts from idle, or from done once the inputs move on
  assign req_changed = (addr_i != addr_q) || (mem_op_i != op_q);
  assign req_start   = avalid_i &&
                       (state_q == REQ_IDLE || (state_q == REQ_DONE && req_changed));

  // effective state of this cycle, so the bus sees the request right away
  always_comb begin
    state_cur = state_q;
    if (req_start) begin
      if (is_load_op(mem_op_i)) begin
        state_cur = REQ_READ;
      end else if (is_store_op(mem_op_i)) begin
        state_cur = REQ_WRITE;
      end else begin
        state_cur = REQ_IDLE;
      end
    end else if (state_q == REQ_DONE && !avalid_i) begin
      state_cur = REQ_IDLE;
    end
  end

  always_comb begin
    state_d = state_cur;
    case (state_cur)
      REQ_READ:  if (bus_rvalid_i || hit_i) state_d = REQ_DONE;
      REQ_WRITE: if (bus_wready_i) state_d = REQ_DONE;
      default:   ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= REQ_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // request being served, to spot a change while done
  always_ff @(posedge clk) begin
    if (req_start) begin
      addr_q <= addr_i;
      op_q   <= mem_op_i;
    end
  end

  // a hit answers the load without touching the bus
  assign arvalid_o = (state_cur == REQ_READ) && !hit_i;
  assign araddr_o  = addr_i;

  assign awvalid_o = (state_cur == REQ_WRITE);
  assign wvalid_o  = (state_cur == REQ_WRITE);
  assign awaddr_o  = addr_i;
  assign wdata_o   = wdata_i;

  // the bus only answers a request that is still open
  a_answer_open: assert property (@(posedge clk) disable iff (rst)
    (!bus_rvalid_i || arvalid_o) && (!bus_wready_i || awvalid_o));

  a_rstrb_stable: assert property (@(posedge clk) disable iff (rst)
    (arvalid_o && $past(arvalid_o)) |-> $stable(rstrb_o));

  a_wstrb_stable: assert property (@(posedge clk) disable iff (rst)
    (wvalid_o && $past(wvalid_o)) |-> $stable(wstrb_o));

endmodule

/* source/l1d_cache.sv */
`include "lsu_config.svh"

module l1d_cache import lsu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`LSU_DATA_W-1:0] addr_i,
  input  mem_op_e                mem_op_i,
  input  logic                   avalid_i,
  input  logic [`LSU_DATA_W-1:0] rdata_i,
  input  logic                   bus_rvalid_i,
  input  logic                   bus_wready_i,
  output logic                   hit_o,
  output logic [`LSU_DATA_W-1:0] word_o,
  output logic                   word_valid_o
);

  localparam int LINES = 1 << `LSU_L1D_IDX_W;
  localparam int TAG_W = `LSU_DATA_W - `LSU_L1D_IDX_W - 2;

  // line storage
  logic [`LSU_DATA_W-1:0] data_q [LINES];
  logic [TAG_W-1:0]       tag_q  [LINES];
  logic [LINES-1:0]       valid_q;

  // return register for loads outside the cacheable windows
  logic [`LSU_DATA_W-1:0] unc_q;
  logic                   unc_pend_q;

  logic [`LSU_L1D_IDX_W-1:0] idx;
  logic [TAG_W-1:0]          tag;
  logic                      tag_match;
  logic                      cacheable;
  logic                      load_req;
  logic                      store_req;
  logic                      fill;
  logic                      unc_load;
  logic                      inval;

  assign idx = addr_i[`LSU_L1D_IDX_W+1:2];
  assign tag = addr_i[`LSU_DATA_W-1:`LSU_L1D_IDX_W+2];

  assign cacheable =
    (addr_i >= `LSU_CACHE_BASE0 && addr_i < `LSU_CACHE_END0) ||
    (addr_i >= `LSU_CACHE_BASE1 && addr_i < `LSU_CACHE_END1) ||
    (addr_i >= `LSU_CACHE_BASE2 && addr_i < `LSU_CACHE_END2);

  assign load_req  = avalid_i && is_load_op(mem_op_i);
  assign store_req = avalid_i && is_store_op(mem_op_i);

  // lookup
  assign tag_match = valid_q[idx] && (tag_q[idx] == tag);
  assign hit_o     = load_req && tag_match;

  // read return goes to a line or to the uncached register
  assign fill     = load_req && bus_rvalid_i && cacheable;
  assign unc_load = load_req && bus_rvalid_i && !cacheable;

  // write-through, no allocate, so a matching line just goes stale
  assign inval = store_req && bus_wready_i && tag_match;

  always_ff @(posedge clk) begin
    if (fill) begin
      data_q[idx] <= rdata_i;
      tag_q[idx]  <= tag;
    end
    if (unc_load) begin
      unc_q <= rdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q    <= '0;
      unc_pend_q <= 1'b0;
    end else begin
      if (fill) begin
        valid_q[idx] <= 1'b1;
      end else if (inval) begin
        valid_q[idx] <= 1'b0;
      end
      // one cycle only, the execute stage takes it right away
      unc_pend_q <= unc_load;
    end
  end

  assign word_o       = unc_pend_q ? unc_q : data_q[idx];
  assign word_valid_o = hit_o || unc_pend_q;

  // uncached words never land in a line, so both sources cannot fire at once
  a_hit_vs_pend: assert property (@(posedge clk) disable iff (rst)
    !(hit_o && unc_pend_q));

  // filled line serves the held request in the next cycle
  a_fill_then_hit: assert property (@(posedge clk) disable iff (rst)
    fill |=> (hit_o || !avalid_i));

endmodule

/* source/load_align.sv */
`include "lsu_config.svh"

module load_align import lsu_pkg::*; (
  input  logic [1:0]             addr_lo_i,
  input  mem_op_e                mem_op_i,
  input  logic [`LSU_DATA_W-1:0] word_i,
  output logic [`LSU_DATA_W-1:0] rdata_o
);

  logic [`LSU_DATA_W-1:0] shifted;
  logic [4:0]             shamt;

  // byte offset to bit offset
  assign shamt   = {addr_lo_i, 3'b000};
  assign shifted = word_i >> shamt;

  always_comb begin
    case (mem_op_i)
      MEM_LB: begin
        rdata_o = {{(`LSU_DATA_W-8){shifted[7]}}, shifted[7:0]};
      end
      MEM_LBU: begin
        rdata_o = {{(`LSU_DATA_W-8){1'b0}}, shifted[7:0]};
      end
      MEM_LH: begin
        rdata_o = {{(`LSU_DATA_W-16){shifted[15]}}, shifted[15:0]};
      end
      MEM_LHU: begin
        rdata_o = {{(`LSU_DATA_W-16){1'b0}}, shifted[15:0]};
      end
      MEM_LW: begin
        // word accesses are aligned
        rdata_o = word_i;
      end
      default: begin
        rdata_o = shifted;
      end
    endcase
  end

endmodule

/* source/lsu_top.sv */
`include "lsu_config.svh"

module lsu_top import lsu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,

  // execute stage
  input  logic [`LSU_DATA_W-1:0] addr_i,
  input  mem_op_e                mem_op_i,
  input  logic                   avalid_i,
  input  logic [`LSU_DATA_W-1:0] wdata_i,
  output logic [`LSU_DATA_W-1:0] rdata_o,
  output logic                   rvalid_o,
  output logic                   wready_o,

  // bus read channel
  output logic [`LSU_DATA_W-1:0] araddr_o,
  output logic                   arvalid_o,
  output logic [7:0]             rstrb_o,
  input  logic [`LSU_DATA_W-1:0] rdata_i,
  input  logic                   bus_rvalid_i,

  // bus write channel
  output logic [`LSU_DATA_W-1:0] awaddr_o,
  output logic                   awvalid_o,
  output logic [`LSU_DATA_W-1:0] wdata_o,
  output logic [7:0]             wstrb_o,
  output logic                   wvalid_o,
  input  logic                   bus_wready_i
);

  logic                   hit;
  logic [`LSU_DATA_W-1:0] word;
  logic                   word_valid;

  lsu_req_gen u_req_gen (
    .clk          (clk),
    .rst          (rst),
    .addr_i       (addr_i),
    .mem_op_i     (mem_op_i),
    .avalid_i     (avalid_i),
    .wdata_i      (wdata_i),
    .hit_i        (hit),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_wready_i (bus_wready_i),
    .araddr_o     (araddr_o),
    .arvalid_o    (arvalid_o),
    .rstrb_o      (rstrb_o),
    .awaddr_o     (awaddr_o),
    .awvalid_o    (awvalid_o),
    .wdata_o      (wdata_o),
    .wstrb_o      (wstrb_o),
    .wvalid_o     (wvalid_o)
  );

  l1d_cache u_l1d_cache (
    .clk          (clk),
    .rst          (rst),
    .addr_i       (addr_i),
    .mem_op_i     (mem_op_i),
    .avalid_i     (avalid_i),
    .rdata_i      (rdata_i),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_wready_i (bus_wready_i),
    .hit_o        (hit),
    .word_o       (word),
    .word_valid_o (word_valid)
  );

  load_align u_load_align (
    .addr_lo_i (addr_i[1:0]),
    .mem_op_i  (mem_op_i),
    .word_i    (word),
    .rdata_o   (rdata_o)
  );

  assign rvalid_o = word_valid;
  // store completes when the bus takes it
  assign wready_o = bus_wready_i;

endmodule

/* test/bus_mem_model.sv */
module bus_mem_model (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] araddr_i,
  input  logic        arvalid_i,
  input  logic [31:0] awaddr_i,
  input  logic        awvalid_i,
  input  logic [31:0] wdata_i,
  input  logic [7:0]  wstrb_i,
  output logic [31:0] rdata_o,
  output logic        rvalid_o,
  output logic        wready_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // sparse word memory, indexed by word address
  logic [31:0] mem [logic [29:0]];
  integer      seed;
  int          cnt;
  logic        busy;
  logic        is_wr;
  int          rd_count;
  int          wr_count;

  // preloaded contents, a function of the whole word address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ 32'h43a5_96f0;
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (mem.exists(addr[31:2])) begin
      return mem[addr[31:2]];
    end
    return fill_word(addr);
  endfunction

  initial begin
    seed     = 32'ha960_bf20;
    rdata_o  = '0;
    rvalid_o = 1'b0;
    wready_o = 1'b0;
    busy     = 1'b0;
    is_wr    = 1'b0;
    cnt      = 0;
    rd_count = 0;
    wr_count = 0;
  end

  always @(posedge clk) begin : answer
    logic [31:0] w;
    rvalid_o <= 1'b0;
    wready_o <= 1'b0;
    if (rst) begin
      busy = 1'b0;
      cnt  = 0;
    end else begin
      // no new request on the edge where the last answer is taken
      if (!busy && !rvalid_o && !wready_o && (arvalid_i || awvalid_i)) begin
        busy  = 1'b1;
        is_wr = awvalid_i;
        cnt   = $unsigned($random(seed)) % 4;
      end
      if (busy) begin
        if (cnt == 0) begin
          busy = 1'b0;
          if (is_wr) begin
            w = read_word(awaddr_i);
            for (int b = 0; b < 4; b++) begin
              if (wstrb_i[b]) w[8*b +: 8] = wdata_i[8*b +: 8];
            end
            mem[awaddr_i[31:2]] = w;
            wready_o <= 1'b1;
            wr_count++;
          end else begin
            rdata_o  <= read_word(araddr_i);
            rvalid_o <= 1'b1;
            rd_count++;
          end
        end else begin
          cnt--;
        end
      end
    end
  end

endmodule

/* test/lsu_tb.sv */
`include "lsu_config.svh"

module lsu_tb import lsu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_OPS = 48;
  localparam int TIMEOUT = 50;
  localparam logic [31:0] UNC_A = 32'h1000_0040;
  localparam logic [31:0] UNC_S = 32'h1000_0080;
  localparam logic [31:0] C_A   = 32'h8000_0020;
  localparam logic [31:0] C_B   = 32'hA000_0104;
  localparam logic [31:0] C_D   = 32'h3000_0008;

  logic clk;
  logic rst;
  logic [`LSU_DATA_W-1:0] addr_i;
  mem_op_e                mem_op_i;
  logic                   avalid_i;
  logic [`LSU_DATA_W-1:0] wdata_i;
  logic [`LSU_DATA_W-1:0] rdata_o;
  logic                   rvalid_o;
  logic                   wready_o;
  logic [`LSU_DATA_W-1:0] araddr_o;
  logic                   arvalid_o;
  logic [7:0]             rstrb_o;
  logic [`LSU_DATA_W-1:0] rdata_i;
  logic                   bus_rvalid_i;
  logic [`LSU_DATA_W-1:0] awaddr_o;
  logic                   awvalid_o;
  logic [`LSU_DATA_W-1:0] wdata_o;
  logic [7:0]             wstrb_o;
  logic                   wvalid_o;
  logic                   bus_wready_i;

  // operation table, expected column is load data or the word after a store
  int          t_test  [MAX_OPS];
  mem_op_e     t_op    [MAX_OPS];
  logic [31:0] t_addr  [MAX_OPS];
  logic [31:0] t_wdata [MAX_OPS];
  logic [31:0] t_exp   [MAX_OPS];
  int          t_reads [MAX_OPS];
  int          n_ops;

  logic [31:0] ref_mem [logic [29:0]];
  int   errors;
  int   test_errs;
  int   ar_rises;
  logic ar_prev;

  lsu_top uut (.*);

  bus_mem_model bus (
    .clk (clk), .rst (rst),
    .araddr_i (araddr_o), .arvalid_i (arvalid_o),
    .awaddr_i (awaddr_o), .awvalid_i (awvalid_o),
    .wdata_i (wdata_o), .wstrb_i (wstrb_o),
    .rdata_o (rdata_i), .rvalid_o (bus_rvalid_i), .wready_o (bus_wready_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // each rising arvalid_o is one bus read
  always @(posedge clk) begin
    if (rst) begin
      ar_prev <= 1'b0;
    end else begin
      if (arvalid_o && !ar_prev) ar_rises++;
      ar_prev <= arvalid_o;
    end
  end

  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    if (ref_mem.exists(addr[31:2])) return ref_mem[addr[31:2]];
    return {addr[31:2], 2'b00} ^ 32'h43a5_96f0;
  endfunction

  function automatic logic [7:0] strobe_for(input mem_op_e op);
    case (op)
      MEM_LB, MEM_LBU, MEM_SB: return 8'h01;
      MEM_LH, MEM_LHU, MEM_SH: return 8'h03;
      MEM_LW, MEM_SW:          return 8'h0f;
      default:                 return 8'h00;
    endcase
  endfunction

  function automatic logic [31:0] expect_load(input mem_op_e op, input logic [31:0] addr,
                                              input logic [31:0] word);
    logic [31:0] s;
    s = word >> (8 * addr[1:0]);
    case (op)
      MEM_LB:  return {{24{s[7]}}, s[7:0]};
      MEM_LBU: return {24'h0, s[7:0]};
      MEM_LH:  return {{16{s[15]}}, s[15:0]};
      MEM_LHU: return {16'h0, s[15:0]};
      default: return word;
    endcase
  endfunction

  task automatic add_op(input int test, input mem_op_e op, input logic [31:0] addr,
                        input logic [31:0] wdata, input int reads);
    logic [31:0] w;
    logic [7:0]  strb;
    t_test[n_ops]  = test;
    t_op[n_ops]    = op;
    t_addr[n_ops]  = addr;
    t_wdata[n_ops] = wdata;
    t_reads[n_ops] = reads;
    if (is_store_op(op)) begin
      w    = ref_word(addr);
      strb = strobe_for(op);
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) w[8*b +: 8] = wdata[8*b +: 8];
      end
      ref_mem[addr[31:2]] = w;
      t_exp[n_ops] = w;
    end else begin
      t_exp[n_ops] = expect_load(op, addr, ref_word(addr));
    end
    n_ops++;
  endtask

  task automatic build_table();
    for (int o = 0; o < 4; o++) add_op(2, MEM_LB, UNC_A + o, 0, 1);
    for (int o = 0; o < 4; o++) add_op(2, MEM_LBU, UNC_A + o, 0, 1);
    for (int o = 0; o < 4; o += 2) add_op(2, MEM_LH, UNC_A + o, 0, 1);
    for (int o = 0; o < 4; o += 2) add_op(2, MEM_LHU, UNC_A + o, 0, 1);
    add_op(2, MEM_LW, UNC_A, 0, 1);
    add_op(3, MEM_LW, C_A, 0, 1);
    add_op(3, MEM_LW, C_A, 0, 0);
    add_op(3, MEM_LB, C_A + 3, 0, 0);
    add_op(3, MEM_LH, C_B, 0, 1);
    add_op(3, MEM_LHU, C_B + 2, 0, 0);
    add_op(4, MEM_SB, UNC_S, 32'hdead_bea5, 0);
    add_op(4, MEM_SH, UNC_S + 4, 32'h1357_f00d, 0);
    add_op(4, MEM_SW, UNC_S + 8, 32'hcafe_0123, 0);
    add_op(5, MEM_SW, C_A, 32'h1234_5687, 0);
    add_op(5, MEM_LW, C_A, 0, 1);
    add_op(5, MEM_LB, C_A, 0, 0);
    add_op(6, MEM_LW, C_D, 0, 1);
    add_op(6, MEM_SW, C_D, 32'h8899_aabb, 0);
    add_op(6, MEM_LHU, C_D + 2, 0, 1);
    add_op(6, MEM_LB, 32'h1000_0101, 0, 1);
    add_op(6, MEM_SH, C_B, 32'h0000_7e81, 0);
    add_op(6, MEM_LH, C_B, 0, 1);
    add_op(6, MEM_LH, C_B, 0, 0);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
      errors++;
      test_errs++;
    end
  endtask

  task automatic run_op(input int i);
    int          cycles;
    bit          done;
    bit          load;
    int          rises0;
    int          rd0;
    int          wr0;
    logic [31:0] got;
    load   = is_load_op(t_op[i]);
    rises0 = ar_rises;
    rd0    = bus.rd_count;
    wr0    = bus.wr_count;
    addr_i   = t_addr[i];
    mem_op_i = t_op[i];
    wdata_i  = t_wdata[i];
    avalid_i = 1'b1;
    #1;
    if (load) begin
      check_value("rstrb_o", strobe_for(t_op[i]), rstrb_o);
      // a miss raises the read in the request cycle, a hit never does
      check_value("arvalid_o", (t_reads[i] != 0), arvalid_o);
      if (t_reads[i] != 0) begin
        check_value("araddr_o", t_addr[i], araddr_o);
      end
    end else begin
      check_value("wstrb_o", strobe_for(t_op[i]), wstrb_o);
      check_value("awaddr_o", t_addr[i], awaddr_o);
      check_value("wdata_o", t_wdata[i], wdata_o);
      check_value("awvalid_o", 1, awvalid_o);
      check_value("wvalid_o", 1, wvalid_o);
    end
    done   = 1'b0;
    cycles = 0;
    while (!done && cycles < TIMEOUT) begin
      if (load) begin
        if (rvalid_o) begin
          got  = rdata_o;
          done = 1'b1;
        end
      end else begin
        // wready_o tracks the bus answer in every cycle of the wait
        check_value("wready_o", bus_wready_i, wready_o);
        if (bus_wready_i) begin
          done = 1'b1;
        end
      end
      @(posedge clk);
      #1;
      cycles++;
    end
    avalid_i = 1'b0;
    mem_op_i = MEM_NONE;
    if (!done) begin
      $display("timeout: entry %0d got no answer within %0d cycles", i, TIMEOUT);
      errors++;
      test_errs++;
    end else if (load) begin
      check_value("rdata_o", t_exp[i], got);
    end else begin
      check_value("memory word", t_exp[i], bus.read_word(t_addr[i]));
    end
    // one idle cycle between entries
    @(posedge clk);
    #1;
    check_value("bus reads", t_reads[i], ar_rises - rises0);
    check_value("bus read answers", t_reads[i], bus.rd_count - rd0);
    check_value("bus writes", load ? 0 : 1, bus.wr_count - wr0);
  endtask

  initial begin
    rst      = 1'b1;
    addr_i   = '0;
    mem_op_i = MEM_NONE;
    avalid_i = 1'b0;
    wdata_i  = '0;
    errors   = 0;
    ar_rises = 0;
    n_ops    = 0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    test_errs = 0;
    check_value("arvalid_o", 0, arvalid_o);
    check_value("awvalid_o", 0, awvalid_o);
    check_value("wvalid_o", 0, wvalid_o);
    check_value("rvalid_o", 0, rvalid_o);
    $display("test 1: outputs after reset, %0d errors", test_errs);
    build_table();
    test_errs = 0;
    for (int i = 0; i < n_ops; i++) begin
      run_op(i);
      if (i == n_ops - 1 || t_test[i + 1] != t_test[i]) begin
        $display("test %0d: finished at entry %0d, %0d errors", t_test[i], i, test_errs);
        test_errs = 0;
      end
    end
    $display("ops=%0d bus_reads=%0d bus_writes=%0d errors=%0d",
             n_ops, bus.rd_count, bus.wr_count, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+include
source/lsu_pkg.sv
source/lsu_req_gen.sv
source/l1d_cache.sv
source/load_align.sv
source/lsu_top.sv
test/bus_mem_model.sv
test/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu_l1d

export_include_dirs:
  - include

sources:
  - files:
      - source/lsu_pkg.sv
      - source/lsu_req_gen.sv
      - source/l1d_cache.sv
      - source/load_align.sv
      - source/lsu_top.sv
  - target: test
    files:
      - test/bus_mem_model.sv
      - test/lsu_tb.sv
